// File: tb.f
source/cpu_pkg.sv
source/pipe_valid_reg.sv
source/pc_gen.sv
source/if_stage.sv
source/regfile.sv
source/id_stage.sv
source/ex_stage.sv
source/wb_stage.sv
source/cpu_core.sv
tb/tb_cpu_core.sv

// File: run.sh
#!/bin/sh
# build and run the cpu_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_cpu_core -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
exit 0

// File: tb/tb_cpu_core.sv
// testbench for cpu_core: clock, reset, sram model, program builder, reference model, checks
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

  localparam logic [63:0] PC_BASE = 64'h8000_0000;

  logic               clk;
  logic               reset;
  logic               sram_ren;
  logic [31:0]        sram_addr;
  logic [63:0]        sram_rdata;
  cpu_pkg::wb_trace_t trace;

  logic [31:0] prog [0:127]; // instruction image, word per pc
  int          prog_len;
  logic [63:0] loop_pc;
  logic [63:0] m_pc;         // reference model state
  logic [63:0] m_regs [0:31];
  integer      seed;
  int          errors;
  int          retired;
  int          exp_count;
  int          rst_cycles;
  bit          released;
  bit          addr_checked;
  bit          done;

  cpu_core #(
    .PC_RESETVAL       (PC_BASE),
    .SRAM_ADDR_WD      (32)
  ) dut0 (
    .i_clk             (clk),
    .i_reset           (reset),
    .o_inst_sram_ren   (sram_ren),
    .o_inst_sram_addr  (sram_addr),
    .i_inst_sram_rdata (sram_rdata),
    .o_wb_trace        (trace)
  );

  always #20 clk = ~clk;

  function automatic int pick(int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // random addi, lui or register-register op on x0..x7
  function automatic logic [31:0] alu_word();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    int         r;
    rd  = 5'(pick(8));
    rs1 = 5'(pick(8));
    rs2 = 5'(pick(8));
    r   = $random(seed);
    case (pick(7))
      0:       return {r[11:0], rs1, 3'b000, rd, 7'b0010011};
      1:       return {r[19:0], rd, 7'b0110111};
      2:       return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      3:       return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011}; // sub
      4:       return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
      5:       return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
      default: return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
    endcase
  endfunction

  task automatic place_word(logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_program();
    int         k;
    logic [4:0] ra;
    logic [4:0] rb;
    for (int i = 0; i < 128; i++) begin
      prog[i] = ~(PC_BASE[31:0] + 32'(i * 4)); // filler, never retired
    end
    prog_len = 0;
    while (prog_len < 58) begin
      case (pick(5))
        3: begin // forward beq/bne over 1 or 2 instructions
          k  = 1 + pick(2);
          ra = 5'(pick(8));
          rb = (pick(2) == 0) ? ra : 5'(pick(8));
          place_word(b_type(13'((k + 1) * 4), rb, ra, 3'(pick(2))));
          for (int i = 0; i < k; i++) begin
            place_word(alu_word());
          end
        end
        4: begin // jal then a dependent jalr on the link register
          ra = 5'(1 + pick(7));
          place_word(j_type(21'd8, ra));
          place_word(alu_word()); // skipped slot
          place_word({12'(12 + pick(2)), ra, 3'b000, 5'(pick(8)), 7'b1100111});
          place_word(alu_word());
        end
        default: place_word(alu_word());
      endcase
    end
    loop_pc = PC_BASE + 64'(prog_len * 4);
    place_word(j_type(21'd0, 5'd0)); // self-loop
  endtask

  task automatic model_reset();
    m_pc = PC_BASE;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = 64'd0;
    end
  endtask

  // executes one instruction by the rv64i rules
  task automatic model_step(output logic [63:0] e_pc, output logic [4:0] e_rd,
                            output logic e_wen, output logic [63:0] e_data);
    logic [31:0] ins;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_b;
    logic [63:0] nxt;
    ins    = prog[m_pc[8:2]];
    a      = m_regs[ins[19:15]];
    b      = m_regs[ins[24:20]];
    imm_i  = {{52{ins[31]}}, ins[31:20]};
    imm_b  = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    nxt    = m_pc + 64'd4;
    e_pc   = m_pc;
    e_rd   = ins[11:7];
    e_wen  = 1'b0;
    e_data = 64'd0;
    case (ins[6:0])
      7'b0010011: if (ins[14:12] == 3'b000) {e_wen, e_data} = {1'b1, a + imm_i};
      7'b0110111: {e_wen, e_data} = {1'b1, {{32{ins[31]}}, ins[31:12], 12'd0}};
      7'b0110011: begin
        e_wen = 1'b1;
        case (ins[14:12])
          3'b000:  e_data = ins[30] ? a - b : a + b;
          3'b100:  e_data = a ^ b;
          3'b110:  e_data = a | b;
          3'b111:  e_data = a & b;
          default: e_wen = 1'b0;
        endcase
      end
      7'b1100011: begin
        if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
          nxt = m_pc + imm_b;
        end
      end
      7'b1101111: begin
        {e_wen, e_data} = {1'b1, m_pc + 64'd4};
        nxt = m_pc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b1100111: begin
        {e_wen, e_data} = {1'b1, m_pc + 64'd4};
        nxt = (a + imm_i) & ~64'd1;
      end
      default: ; // anything else is a no-op
    endcase
    if (e_wen && e_rd != 5'd0) m_regs[e_rd] = e_data;
    m_pc = nxt;
  endtask

  task automatic compare_field(string name, logic [63:0] exp, logic [63:0] act);
    assert (exp === act) else begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // sram returns the 8-byte line one cycle after the read
  always @(posedge clk) begin : sram_model
    logic [31:0] off;
    off = sram_addr - PC_BASE[31:0];
    if (sram_ren) begin
      if (off < 32'd512) begin
        sram_rdata <= {prog[{off[8:3], 1'b1}], prog[{off[8:3], 1'b0}]};
      end else begin
        sram_rdata <= {~(sram_addr + 32'd4), ~sram_addr};
      end
    end
  end

  always @(posedge clk) begin : check_retire
    logic [63:0] e_pc;
    logic [63:0] e_data;
    logic [4:0]  e_rd;
    logic        e_wen;
    if (reset) begin
      if (rst_cycles > 0) begin // registers hold reset values from here on
        compare_field("o_wb_trace.valid", 64'd0, 64'(trace.valid));
        compare_field("o_inst_sram_ren", 64'd0, 64'(sram_ren));
      end
      rst_cycles++;
    end else if (!released) begin
      released = 1'b1;
      compare_field("o_wb_trace.valid", 64'd0, 64'(trace.valid));
      compare_field("o_inst_sram_ren", 64'd0, 64'(sram_ren));
    end else begin
      if (sram_ren && !addr_checked) begin
        addr_checked = 1'b1;
        compare_field("o_inst_sram_addr", PC_BASE, 64'(sram_addr));
      end
      if (trace.valid && !done) begin
        model_step(e_pc, e_rd, e_wen, e_data);
        compare_field("o_wb_trace.pc", e_pc, trace.pc);
        compare_field("o_wb_trace.rd_wen", 64'(e_wen), 64'(trace.rd_wen));
        if (e_wen) begin
          compare_field("o_wb_trace.rd", 64'(e_rd), 64'(trace.rd));
          compare_field("o_wb_trace.data", e_data, trace.data);
        end
        retired++;
        if (trace.pc == loop_pc) done = 1'b1;
      end
    end
  end

  initial begin : watchdog
    wait (prog_len > 0);
    #(4 * prog_len * 40 + 2000);
    $display("timeout: self-loop not reached, %0d instructions retired", retired);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    seed       = 32'hfc38_fe53;
    clk        = 1'b0;
    reset      = 1'b1;
    sram_rdata = 64'd0;
    build_program();
    model_reset();
    exp_count = 1; // the self-loop itself retires once before the end
    while (m_pc != loop_pc && exp_count < 500) begin : count_retires
      logic [63:0] p;
      logic [63:0] d;
      logic [4:0]  r;
      logic        w;
      model_step(p, r, w, d);
      exp_count++;
    end
    model_reset();
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    wait (done);
    repeat (2) @(posedge clk);
    assert (retired == exp_count) else begin
      $display("retired %0d instructions up to the self-loop, model expects %0d",
               retired, exp_count);
      errors++;
    end
    $display("program %0d words, %0d retired, %0d errors", prog_len, retired, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/cpu_core.sv
// top level: fetch, decode, execute and result stages with the register file
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
  parameter logic [cpu_pkg::XLEN-1:0] PC_RESETVAL  = 'h8000_0000,
  parameter int                       SRAM_ADDR_WD = 32
) (
  input  wire logic                             i_clk,
  input  wire logic                             i_reset,
  output logic                                  o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0]               o_inst_sram_addr,
  input  wire logic [cpu_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  output cpu_pkg::wb_trace_t                    o_wb_trace
);

  logic                     fs_to_ds_valid, ds_allowin;
  logic                     ds_to_es_valid, es_allowin;
  logic                     es_to_ws_valid, ws_allowin;
  cpu_pkg::fs_to_ds_t       fs_to_ds;
  cpu_pkg::ds_to_es_t       ds_to_es;
  cpu_pkg::es_to_ws_t       es_to_ws;
  cpu_pkg::br_bus_t         br;
  cpu_pkg::dest_t           es_dest, ws_dest;
  cpu_pkg::rf_wr_t          rf_wr;
  logic [4:0]               raddr1, raddr2;
  logic [cpu_pkg::XLEN-1:0] rdata1, rdata2;

  if_stage #(
    .PC_RESETVAL       (PC_RESETVAL),
    .SRAM_ADDR_WD      (SRAM_ADDR_WD)
  ) u_if_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_ds_allowin      (ds_allowin),
    .i_br              (br),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_to_ds        (fs_to_ds),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  id_stage u_id_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds       (fs_to_ds),
    .o_ds_allowin     (ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es       (ds_to_es),
    .o_br             (br), // resolved branch back to fetch
    .i_es_dest        (es_dest),
    .i_ws_dest        (ws_dest),
    .o_raddr1         (raddr1),
    .o_raddr2         (raddr2),
    .i_rdata1         (rdata1),
    .i_rdata2         (rdata2)
  );

  ex_stage u_ex_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_to_es_valid (ds_to_es_valid),
    .i_ds_to_es       (ds_to_es),
    .o_es_allowin     (es_allowin),
    .i_ws_allowin     (ws_allowin),
    .o_es_to_ws_valid (es_to_ws_valid),
    .o_es_to_ws       (es_to_ws),
    .o_es_dest        (es_dest)
  );

  wb_stage u_wb_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_es_to_ws_valid (es_to_ws_valid),
    .i_es_to_ws       (es_to_ws),
    .o_ws_allowin     (ws_allowin),
    .o_rf_wr          (rf_wr),
    .o_ws_dest        (ws_dest),
    .o_wb_trace       (o_wb_trace)
  );

  regfile u_regfile (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_raddr1 (raddr1),
    .i_raddr2 (raddr2),
    .o_rdata1 (rdata1),
    .o_rdata2 (rdata2),
    .i_wr     (rf_wr)
  );

endmodule

`default_nettype wire

// File: source/wb_stage.sv
// result stage: register write, hazard destination and retire trace
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
  input  wire logic               i_clk,
  input  wire logic               i_reset,
  input  wire logic               i_es_to_ws_valid,
  input  wire cpu_pkg::es_to_ws_t i_es_to_ws,
  output logic                    o_ws_allowin,
  output cpu_pkg::rf_wr_t         o_rf_wr,
  output cpu_pkg::dest_t          o_ws_dest,
  output cpu_pkg::wb_trace_t      o_wb_trace
);

  cpu_pkg::es_to_ws_t ws;
  logic               ws_valid;
  logic               ws_wen;

  pipe_valid_reg #(
    .T             (cpu_pkg::es_to_ws_t)
  ) u_ws_reg (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_in_valid    (i_es_to_ws_valid),
    .i_in_data     (i_es_to_ws),
    .i_out_allowin (1'b1), // last stage never backs up
    .i_ready_go    (1'b1),
    .i_flush       (1'b0),
    .o_allowin     (o_ws_allowin),
    .o_out_valid   (ws_valid),
    .o_data        (ws)
  );

  assign ws_wen     = ws_valid && ws.rd_wen;
  assign o_rf_wr    = '{wen: ws_wen, addr: ws.rd, data: ws.result};
  assign o_ws_dest  = '{wen: ws_wen, rd: ws.rd};
  assign o_wb_trace = '{valid: ws_valid, pc: ws.pc, rd: ws.rd, rd_wen: ws_wen,
                        data: ws.result};

endmodule

`default_nettype wire

// File: source/ex_stage.sv
// execute stage: stage register and alu
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  wire logic               i_clk,
  input  wire logic               i_reset,
  input  wire logic               i_ds_to_es_valid,
  input  wire cpu_pkg::ds_to_es_t i_ds_to_es,
  output logic                    o_es_allowin,
  input  wire logic               i_ws_allowin,
  output logic                    o_es_to_ws_valid,
  output cpu_pkg::es_to_ws_t      o_es_to_ws,
  output cpu_pkg::dest_t          o_es_dest
);

  cpu_pkg::ds_to_es_t       es;
  logic [cpu_pkg::XLEN-1:0] result;

  pipe_valid_reg #(
    .T             (cpu_pkg::ds_to_es_t)
  ) u_es_reg (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_in_valid    (i_ds_to_es_valid),
    .i_in_data     (i_ds_to_es),
    .i_out_allowin (i_ws_allowin),
    .i_ready_go    (1'b1), // single-cycle alu
    .i_flush       (1'b0),
    .o_allowin     (o_es_allowin),
    .o_out_valid   (o_es_to_ws_valid),
    .o_data        (es)
  );

  always_comb begin
    case (es.alu_op)
      cpu_pkg::ALU_SUB:    result = es.src_a - es.src_b;
      cpu_pkg::ALU_AND:    result = es.src_a & es.src_b;
      cpu_pkg::ALU_OR:     result = es.src_a | es.src_b;
      cpu_pkg::ALU_XOR:    result = es.src_a ^ es.src_b;
      cpu_pkg::ALU_PASS_B: result = es.src_b;
      cpu_pkg::ALU_LINK:   result = es.src_a + 'd4; // src_a carries the pc
      default:             result = es.src_a + es.src_b;
    endcase
  end

  assign o_es_to_ws = '{pc: es.pc, rd: es.rd, rd_wen: es.rd_wen, result: result};
  assign o_es_dest  = '{wen: o_es_to_ws_valid && es.rd_wen, rd: es.rd};

endmodule

`default_nettype wire

// File: source/id_stage.sv
// decode stage: instruction decode, operand read, raw hazard stall, branch resolve
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset,
  input  wire logic                     i_fs_to_ds_valid,
  input  wire cpu_pkg::fs_to_ds_t       i_fs_to_ds,
  output logic                          o_ds_allowin,
  input  wire logic                     i_es_allowin,
  output logic                          o_ds_to_es_valid,
  output cpu_pkg::ds_to_es_t            o_ds_to_es,
  output cpu_pkg::br_bus_t              o_br,
  input  wire cpu_pkg::dest_t           i_es_dest,
  input  wire cpu_pkg::dest_t           i_ws_dest,
  output logic [4:0]                    o_raddr1,
  output logic [4:0]                    o_raddr2,
  input  wire logic [cpu_pkg::XLEN-1:0] i_rdata1,
  input  wire logic [cpu_pkg::XLEN-1:0] i_rdata2
);

  logic                     ds_valid;
  logic                     ds_ready_go;
  logic                     hazard;
  cpu_pkg::fs_to_ds_t       ds;
  logic [31:0]              inst;
  logic [2:0]               funct3;
  logic [4:0]               rs1;
  logic [4:0]               rs2;
  logic [cpu_pkg::XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
  cpu_pkg::alu_op_e         alu_op;
  logic [cpu_pkg::XLEN-1:0] src_a, src_b, br_target;
  logic                     rd_wen, is_cf, take;

  function automatic logic dest_hit(logic [4:0] src, cpu_pkg::dest_t dst);
    return (src != 5'd0) && dst.wen && (dst.rd == src);
  endfunction

  assign inst   = ds.inst;
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign imm_i  = {{52{inst[31]}}, inst[31:20]};
  assign imm_u  = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_b  = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j  = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // no forwarding, so wait until pending writers have retired
  assign hazard = dest_hit(rs1, i_es_dest) || dest_hit(rs1, i_ws_dest) ||
                  dest_hit(rs2, i_es_dest) || dest_hit(rs2, i_ws_dest);
  assign ds_ready_go      = !hazard;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ds_allowin && i_fs_to_ds_valid) begin
      ds <= i_fs_to_ds;
    end
  end

  always_comb begin
    alu_op    = cpu_pkg::ALU_ADD;
    src_a     = i_rdata1;
    src_b     = imm_i;
    rd_wen    = 1'b0; // unknown opcodes retire as no-ops
    is_cf     = 1'b0;
    take      = 1'b0;
    br_target = ds.pc + imm_b;
    case (inst[6:0])
      cpu_pkg::OPC_OP_IMM: rd_wen = (funct3 == 3'b000); // addi only
      cpu_pkg::OPC_OP: begin
        src_b  = i_rdata2;
        rd_wen = 1'b1;
        case (funct3)
          3'b000:  alu_op = inst[30] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
          3'b100:  alu_op = cpu_pkg::ALU_XOR;
          3'b110:  alu_op = cpu_pkg::ALU_OR;
          3'b111:  alu_op = cpu_pkg::ALU_AND;
          default: rd_wen = 1'b0;
        endcase
      end
      cpu_pkg::OPC_LUI: begin
        alu_op = cpu_pkg::ALU_PASS_B;
        src_b  = imm_u;
        rd_wen = 1'b1;
      end
      cpu_pkg::OPC_BRANCH: begin
        is_cf = (funct3[2:1] == 2'b00); // beq / bne
        take  = is_cf && (funct3[0] ^ (i_rdata1 == i_rdata2));
      end
      cpu_pkg::OPC_JAL, cpu_pkg::OPC_JALR: begin
        alu_op    = cpu_pkg::ALU_LINK;
        src_a     = ds.pc;
        rd_wen    = 1'b1;
        is_cf     = 1'b1;
        take      = 1'b1;
        br_target = inst[3] ? ds.pc + imm_j
                            : (i_rdata1 + imm_i) & {{(cpu_pkg::XLEN-1){1'b1}}, 1'b0};
      end
      default: ;
    endcase
  end

  assign o_raddr1   = rs1;
  assign o_raddr2   = rs2;
  assign o_ds_to_es = '{pc: ds.pc, alu_op: alu_op, src_a: src_a, src_b: src_b,
                        rd: inst[11:7], rd_wen: rd_wen};

  assign o_br = '{br_stall:  ds_valid && is_cf && hazard,
                  br_taken:  o_ds_to_es_valid && i_es_allowin && take, // on leaving
                  br_target: br_target};

endmodule

`default_nettype wire

// File: source/regfile.sv
// integer register file, two combinational reads and one write, x0 hardwired
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset,
  input  wire logic [4:0]               i_raddr1,
  input  wire logic [4:0]               i_raddr2,
  output logic [cpu_pkg::XLEN-1:0]      o_rdata1,
  output logic [cpu_pkg::XLEN-1:0]      o_rdata2,
  input  wire cpu_pkg::rf_wr_t          i_wr
);

  logic [cpu_pkg::XLEN-1:0] regs [1:31]; // x1..x31

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.wen && (i_wr.addr != 5'd0)) begin
      regs[i_wr.addr] <= i_wr.data;
    end
  end

  assign o_rdata1 = (i_raddr1 == 5'd0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == 5'd0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// File: source/if_stage.sv
// fetch stage: valid bit, instruction half select and wrong-path drop
`timescale 1ns/1ps
`default_nettype none

module if_stage #(
  parameter logic [cpu_pkg::XLEN-1:0] PC_RESETVAL  = 'h8000_0000,
  parameter int                       SRAM_ADDR_WD = 32
) (
  input  wire logic                         i_clk,
  input  wire logic                         i_reset,
  input  wire logic                         i_ds_allowin,
  input  wire cpu_pkg::br_bus_t             i_br,
  output logic                              o_fs_to_ds_valid,
  output cpu_pkg::fs_to_ds_t                o_fs_to_ds,
  output logic                              o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0]           o_inst_sram_addr,
  input  wire logic [cpu_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata
);

  logic                        fs_valid;
  logic                        fs_allowin;
  logic                        fs_load;
  logic [cpu_pkg::XLEN-1:0]    fs_pc;
  logic [cpu_pkg::INST_WD-1:0] fs_inst;

  // fetch always finishes in one cycle
  assign fs_allowin = !fs_valid || i_ds_allowin;
  assign fs_load    = o_inst_sram_ren && fs_allowin; // ren doubles as run flag

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fs_valid <= 1'b0;
    end else if (fs_load) begin
      fs_valid <= 1'b1;
    end
  end

  pc_gen #(
    .PC_RESETVAL      (PC_RESETVAL),
    .SRAM_ADDR_WD     (SRAM_ADDR_WD)
  ) u_pc_gen (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_load           (fs_load),
    .i_br             (i_br),
    .o_pc             (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  // pc[2] picks the upper word of the 64-bit line
  assign fs_inst = fs_pc[2] ? i_inst_sram_rdata[cpu_pkg::SRAM_DATA_WD-1 -: cpu_pkg::INST_WD]
                            : i_inst_sram_rdata[cpu_pkg::INST_WD-1:0];

  // taken branch leaving decode kills the wrong-path instruction held here
  assign o_fs_to_ds_valid = fs_valid && !i_br.br_taken;
  assign o_fs_to_ds       = '{inst: fs_inst, pc: fs_pc};

endmodule

`default_nettype wire

// File: source/pc_gen.sv
// pc register and next pc selection feeding the instruction sram read port
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
  parameter logic [cpu_pkg::XLEN-1:0] PC_RESETVAL  = 'h8000_0000,
  parameter int                       SRAM_ADDR_WD = 32
) (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_load,
  input  wire cpu_pkg::br_bus_t      i_br,
  output logic [cpu_pkg::XLEN-1:0]   o_pc,
  output logic                       o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0]    o_inst_sram_addr
);

  logic [cpu_pkg::XLEN-1:0] next_pc;

  always_comb begin
    if (i_br.br_taken) begin
      next_pc = i_br.br_target;
    end else if (i_load && !i_br.br_stall) begin
      next_pc = o_pc + 'd4;
    end else begin
      next_pc = o_pc; // re-read the same word while held
    end
  end

  assign o_inst_sram_addr = {next_pc[SRAM_ADDR_WD-1:3], 3'b000}; // 8-byte aligned

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_pc            <= PC_RESETVAL - 'd4; // first next_pc is PC_RESETVAL
      o_inst_sram_ren <= 1'b0;
    end else begin
      o_pc            <= next_pc;
      o_inst_sram_ren <= 1'b1; // reads start one cycle after reset
    end
  end

endmodule

`default_nettype wire

// File: source/pipe_valid_reg.sv
// generic stage register with valid/allowin handshake and typed payload
`timescale 1ns/1ps
`default_nettype none

module pipe_valid_reg #(
  parameter type T = logic
) (
  input  wire logic i_clk,
  input  wire logic i_reset,
  input  wire logic i_in_valid,
  input  wire T     i_in_data,
  input  wire logic i_out_allowin,
  input  wire logic i_ready_go,
  input  wire logic i_flush,
  output logic      o_allowin,
  output logic      o_out_valid,
  output T          o_data
);

  logic valid;

  // empty, or the current entry moves on this cycle
  assign o_allowin   = !valid || (i_ready_go && i_out_allowin);
  assign o_out_valid = valid && i_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset || i_flush) begin
      valid <= 1'b0;
    end else if (o_allowin) begin
      valid <= i_in_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_allowin && i_in_valid) begin
      o_data <= i_in_data; // payload only moves on a transfer
    end
  end

endmodule

`default_nettype wire

// File: source/cpu_pkg.sv
// package with widths, opcodes, alu operations and the stage bus structs
`default_nettype none

package cpu_pkg;

  localparam int XLEN         = 64;
  localparam int INST_WD      = 32;
  localparam int SRAM_DATA_WD = 64; // two instructions per sram word

  // rv64i major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B, // lui
    ALU_LINK    // pc+4 for jal/jalr
  } alu_op_e;

  // decode -> fetch
  typedef struct packed {
    logic            br_stall;
    logic            br_taken;
    logic [XLEN-1:0] br_target;
  } br_bus_t;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [XLEN-1:0]    pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    alu_op_e         alu_op;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [4:0]      rd;
    logic            rd_wen;
  } ds_to_es_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [4:0]      rd;
    logic            rd_wen;
    logic [XLEN-1:0] result;
  } es_to_ws_t;

  typedef struct packed {
    logic            wen;
    logic [4:0]      addr;
    logic [XLEN-1:0] data;
  } rf_wr_t;

  // pending destination of a later stage, for the hazard check
  typedef struct packed {
    logic       wen;
    logic [4:0] rd;
  } dest_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [4:0]      rd;
    logic            rd_wen;
    logic [XLEN-1:0] data;
  } wb_trace_t;

endpackage

`default_nettype wire
